// ==== Makefile ====
# Verilator build and run of the convolution tap unit testbench

VERILATOR ?= verilator
TOP       ?= conv_unit_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
FAIL_MSG  ?= SOME TESTS FAILED
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+common
common/conv_pkg.sv
rf/rf_2p.sv
src/weight_loader.sv
src/conv_mac.sv
src/conv_unit_top.sv
test/conv_unit_assert.sv
test/conv_unit_tb.sv

// ==== common/conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// weight, pixel and register-file word width, signed
`define CONV_DWD 16

// register-file depth in words
`define CONV_WORD_WD 12

// register-file address width for 12 words
`define CONV_AWD 4

// taps of one 3x3 kernel window
`define CONV_TAPS 9

// accumulator and result width, holds nine full-scale products
`define CONV_ACC_WD 40

`endif

// ==== common/conv_pkg.sv ====
package conv_pkg;

    // operation on the shared input stream
    // held at one value for the whole stream
    typedef enum logic [1:0] {
        OP_NOP  = 2'd0,  // word ignored
        OP_LOAD = 2'd1,  // word is a kernel weight
        OP_CONV = 2'd2   // word is a window pixel
    } conv_op_e;

    // engine window state
    typedef enum logic {
        MAC_IDLE  = 1'b0,  // no pixel of the window seen yet
        MAC_ACCUM = 1'b1   // window in progress
    } mac_state_e;

endpackage

// ==== rf/rf_2p.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module rf_2p #(
    parameter int word_wd = `CONV_WORD_WD,
    parameter int data_wd = `CONV_DWD,
    parameter int addr_wd = $clog2(word_wd)
) (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_read,
    input  logic               i_write,
    input  logic [addr_wd-1:0] i_raddr,
    input  logic [addr_wd-1:0] i_waddr,
    input  logic [data_wd-1:0] i_wdata,
    output logic [data_wd-1:0] o_rdata,
    output logic               o_rvalid
);

    logic [data_wd-1:0] mem [word_wd];  // word array, stands in for the macro
    logic [data_wd-1:0] rdata_q;
    logic               rvalid_q;

    // write port
    always_ff @(posedge i_clk) begin
        if (i_write) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // read port, same-cycle write to the same word returns the old word
    always_ff @(posedge i_clk) begin
        if (i_read) begin
            rdata_q <= mem[i_raddr];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= i_read;  // one cycle behind the strobe
        end
    end

    assign o_rdata  = rdata_q;
    assign o_rvalid = rvalid_q;

endmodule

// ==== src/conv_mac.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_mac (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  conv_pkg::conv_op_e             i_op,
    input  logic                           i_data_valid,
    input  logic signed [`CONV_DWD-1:0]    i_data,
    input  logic signed [`CONV_DWD-1:0]    i_rdata,
    input  logic                           i_rvalid,
    output logic                           o_read,
    output logic [`CONV_AWD-1:0]           o_raddr,
    output logic                           o_result_valid,
    output logic signed [`CONV_ACC_WD-1:0] o_result
);

    localparam int last_tap = `CONV_TAPS - 1;
    localparam int prod_wd  = 2 * `CONV_DWD;

    logic                 pix_accept;
    conv_pkg::mac_state_e state_q;
    logic [`CONV_AWD-1:0] tap_q;
    logic                 is_last_tap;

    // stage 1, pixel waiting for its weight
    logic signed [`CONV_DWD-1:0] pix_q;
    logic                        s1_first_q;
    logic                        s1_last_q;

    // stage 2, registered product
    logic signed [prod_wd-1:0]   prod_q;
    logic                        s2_valid_q;
    logic                        s2_first_q;
    logic                        s2_last_q;

    // stage 3, accumulate and result
    logic signed [`CONV_ACC_WD-1:0] prod_ext;
    logic signed [`CONV_ACC_WD-1:0] acc_q;
    logic signed [`CONV_ACC_WD-1:0] sum;
    logic signed [`CONV_ACC_WD-1:0] result_q;
    logic                           result_valid_q;

    assign pix_accept  = i_data_valid && (i_op == conv_pkg::OP_CONV);
    assign is_last_tap = (tap_q == last_tap[`CONV_AWD-1:0]);

    // weight read goes out with the pixel
    assign o_read  = pix_accept;
    assign o_raddr = tap_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= conv_pkg::MAC_IDLE;
            tap_q   <= '0;
        end else if (pix_accept) begin
            if (is_last_tap) begin
                state_q <= conv_pkg::MAC_IDLE;  // window done
                tap_q   <= '0;
            end else begin
                state_q <= conv_pkg::MAC_ACCUM;
                tap_q   <= tap_q + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (pix_accept) begin
            pix_q      <= i_data;
            s1_first_q <= (state_q == conv_pkg::MAC_IDLE);
            s1_last_q  <= is_last_tap;
        end
    end

    // weight arrives with rvalid, pair it with the held pixel
    always_ff @(posedge i_clk) begin
        if (i_rvalid) begin
            prod_q     <= i_rdata * pix_q;
            s2_first_q <= s1_first_q;
            s2_last_q  <= s1_last_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            s2_valid_q <= 1'b0;
        end else begin
            s2_valid_q <= i_rvalid;
        end
    end

    assign prod_ext = {{(`CONV_ACC_WD - prod_wd){prod_q[prod_wd-1]}}, prod_q};
    assign sum      = s2_first_q ? prod_ext : acc_q + prod_ext;  // first tap restarts

    always_ff @(posedge i_clk) begin
        if (s2_valid_q) begin
            acc_q <= sum;
            if (s2_last_q) begin
                result_q <= sum;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            result_valid_q <= 1'b0;
        end else begin
            result_valid_q <= s2_valid_q && s2_last_q;  // single pulse per window
        end
    end

    assign o_result       = result_q;
    assign o_result_valid = result_valid_q;

endmodule

// ==== src/conv_unit_top.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_unit_top (
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  conv_pkg::conv_op_e             i_op,
    input  logic                           i_data_valid,
    input  logic signed [`CONV_DWD-1:0]    i_data,
    output logic                           o_weights_ready,
    output logic                           o_result_valid,
    output logic signed [`CONV_ACC_WD-1:0] o_result
);

    // loader to register file
    logic                        rf_write;
    logic [`CONV_AWD-1:0]        rf_waddr;
    logic signed [`CONV_DWD-1:0] rf_wdata;

    // engine to register file
    logic                        rf_read;
    logic [`CONV_AWD-1:0]        rf_raddr;
    logic signed [`CONV_DWD-1:0] rf_rdata;
    logic                        rf_rvalid;

    weight_loader weight_loader_inst (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_op            (i_op),
        .i_data_valid    (i_data_valid),
        .i_data          (i_data),
        .o_write         (rf_write),
        .o_waddr         (rf_waddr),
        .o_wdata         (rf_wdata),
        .o_weights_ready (o_weights_ready)
    );

    rf_2p #(
        .word_wd (`CONV_WORD_WD),
        .data_wd (`CONV_DWD)
    ) rf_2p_inst (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_read   (rf_read),
        .i_write  (rf_write),
        .i_raddr  (rf_raddr),
        .i_waddr  (rf_waddr),
        .i_wdata  (rf_wdata),
        .o_rdata  (rf_rdata),
        .o_rvalid (rf_rvalid)
    );

    conv_mac conv_mac_inst (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_op           (i_op),
        .i_data_valid   (i_data_valid),
        .i_data         (i_data),
        .i_rdata        (rf_rdata),
        .i_rvalid       (rf_rvalid),
        .o_read         (rf_read),
        .o_raddr        (rf_raddr),
        .o_result_valid (o_result_valid),
        .o_result       (o_result)
    );

endmodule

// ==== src/weight_loader.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module weight_loader (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  conv_pkg::conv_op_e          i_op,
    input  logic                        i_data_valid,
    input  logic signed [`CONV_DWD-1:0] i_data,
    output logic                        o_write,
    output logic [`CONV_AWD-1:0]        o_waddr,
    output logic signed [`CONV_DWD-1:0] o_wdata,
    output logic                        o_weights_ready
);

    localparam int last_tap = `CONV_TAPS - 1;

    logic                 load_accept;
    logic [`CONV_AWD-1:0] tap_q;  // next tap address to fill
    logic                 ready_q;

    assign load_accept = i_data_valid && (i_op == conv_pkg::OP_LOAD);

    // weight is stored at the edge that accepts it
    assign o_write = load_accept;
    assign o_waddr = tap_q;
    assign o_wdata = i_data;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            tap_q   <= '0;
            ready_q <= 1'b0;
        end else if (load_accept) begin
            if (tap_q == last_tap[`CONV_AWD-1:0]) begin
                tap_q   <= '0;  // wrap after the ninth weight
                ready_q <= 1'b1;  // full kernel written
            end else begin
                tap_q <= tap_q + 1'b1;
                if (tap_q == '0) begin
                    ready_q <= 1'b0;  // reload started
                end
            end
        end
    end

    assign o_weights_ready = ready_q;

endmodule

// ==== test/conv_unit_assert.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_unit_assert (
    input logic                 i_clk,
    input logic                 i_reset,
    input logic                 i_read,
    input logic                 i_write,
    input logic [`CONV_AWD-1:0] i_waddr,
    input logic                 i_rvalid,
    input logic                 i_result_valid,
    input conv_pkg::mac_state_e i_state
);

    rvalid_follows_read: assert property (@(posedge i_clk) disable iff (i_reset)
        i_rvalid == $past(i_read))
        else $error("read-valid flag is not one cycle behind the read strobe");

    result_single_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_result_valid |=> !i_result_valid)
        else $error("result valid held for two cycles");

    waddr_in_range: assert property (@(posedge i_clk) disable iff (i_reset)
        i_write |-> (int'(i_waddr) < `CONV_WORD_WD))
        else $error("write address beyond the register file");

    no_read_write_clash: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_read && i_write))
        else $error("read and write strobes in the same cycle");

    // result two cycles behind the edge that closes the window
    result_after_window: assert property (@(posedge i_clk) disable iff (i_reset)
        i_result_valid |-> ($past(i_state, 2) == conv_pkg::MAC_IDLE))
        else $error("result valid not two cycles after the last pixel of a window");

endmodule

bind rf_2p conv_unit_assert rf_2p_assert_inst (.i_clk(i_clk), .i_reset(i_reset),
    .i_read(i_read), .i_write(i_write), .i_waddr(i_waddr),
    .i_rvalid(o_rvalid), .i_result_valid(1'b0), .i_state(conv_pkg::MAC_IDLE));

bind conv_mac conv_unit_assert conv_mac_assert_inst (.i_clk(i_clk), .i_reset(i_reset),
    .i_read(o_read), .i_write(1'b0), .i_waddr('0),
    .i_rvalid(i_rvalid), .i_result_valid(o_result_valid), .i_state(state_q));

// ==== test/conv_unit_tb.sv ====
`timescale 1ns/10ps
`include "conv_macros.svh"

module conv_unit_tb;

    localparam int n_rows       = 7;
    localparam int reset_cycles = 5;
    localparam int fill_rand    = 0;
    localparam int fill_min     = 1;
    localparam int fill_max     = 2;
    localparam int fill_alt     = 3;
    localparam int fill_ramp    = 4;

    // columns: load kernel, nop strobes before the row, idle cycles after each strobe,
    // weight fill, pixel fill
    int stim_table [n_rows][5] = '{
        '{1, 0, 0, fill_min,  fill_min},   // full-scale negative times negative
        '{0, 0, 1, fill_rand, fill_rand},  // stored kernel, gapped pixels
        '{1, 2, 0, fill_rand, fill_rand},
        '{0, 0, 0, fill_rand, fill_rand},  // straight after the previous window
        '{1, 3, 1, fill_alt,  fill_max},
        '{0, 1, 0, fill_rand, fill_min},
        '{1, 0, 0, fill_ramp, fill_rand}
    };

    logic                           i_clk;
    logic                           i_reset;
    conv_pkg::conv_op_e             i_op;
    logic                           i_data_valid;
    logic signed [`CONV_DWD-1:0]    i_data;
    logic                           o_weights_ready;
    logic                           o_result_valid;
    logic signed [`CONV_ACC_WD-1:0] o_result;

    int                             cycle_count = 0;
    int                             cycle_limit = 0;
    logic signed [`CONV_DWD-1:0]    kernel [`CONV_TAPS];  // last loaded weights
    int                             res_cyc_q [$];        // accept cycle of ninth pixel
    logic signed [`CONV_ACC_WD-1:0] res_val_q [$];
    int                             rdy_cyc_q [$];
    logic                           rdy_val_q [$];
    logic                           ready_exp = 1'b0;

    conv_unit_top conv_unit_top_inst (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_op            (i_op),
        .i_data_valid    (i_data_valid),
        .i_data          (i_data),
        .o_weights_ready (o_weights_ready),
        .o_result_valid  (o_result_valid),
        .o_result        (o_result)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_result(input logic signed [`CONV_ACC_WD-1:0] exp_val,
                                input logic signed [`CONV_ACC_WD-1:0] act_val);
        if (act_val !== exp_val) begin
            $display("CHECK FAILED at %0t: o_result expected %0d, got %0d",
                     $time, exp_val, act_val);
            stop_run();
        end
    endtask

    task automatic check_ready(input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("CHECK FAILED at %0t: o_weights_ready expected %0b, got %0b",
                     $time, exp_val, act_val);
            stop_run();
        end
    endtask

    function automatic logic signed [`CONV_DWD-1:0] fill_word(input int fill, input int k);
        logic [31:0] rnd;
        int          ramp;
        case (fill)
            fill_min: fill_word = 16'sh8000;
            fill_max: fill_word = 16'sh7fff;
            fill_alt: fill_word = (k % 2 == 0) ? 16'sh7fff : 16'sh8000;
            fill_ramp: begin
                ramp      = k * 1111 - 4444;  // small values around zero
                fill_word = ramp[`CONV_DWD-1:0];
            end
            default: begin
                rnd       = $urandom();
                fill_word = rnd[`CONV_DWD-1:0];
            end
        endcase
    endfunction

    // strobe is accepted at the next rising edge
    task automatic drive_strobe(input conv_pkg::conv_op_e op,
                                input logic signed [`CONV_DWD-1:0] data);
        @(posedge i_clk);
        #2;
        i_op         = op;
        i_data_valid = 1'b1;
        i_data       = data;
    endtask

    task automatic drive_idle();
        @(posedge i_clk);
        #2;
        i_data_valid = 1'b0;
    endtask

    task automatic load_kernel(input int row);
        logic signed [`CONV_DWD-1:0] w;
        for (int k = 0; k < `CONV_TAPS; k++) begin
            w = fill_word(stim_table[row][3], k);
            drive_strobe(conv_pkg::OP_LOAD, w);
            kernel[k] = w;
            rdy_cyc_q.push_back(cycle_count + 1);
            rdy_val_q.push_back(k == `CONV_TAPS - 1);  // ready only once all nine are in
            repeat (stim_table[row][2]) drive_idle();
        end
    endtask

    task automatic run_window(input int row);
        logic signed [`CONV_DWD-1:0] p;
        longint                      acc;
        acc = 0;
        for (int k = 0; k < `CONV_TAPS; k++) begin
            p = fill_word(stim_table[row][4], k);
            drive_strobe(conv_pkg::OP_CONV, p);
            acc = acc + longint'(kernel[k]) * longint'(p);
            if (k == `CONV_TAPS - 1) begin
                res_cyc_q.push_back(cycle_count + 1);
                res_val_q.push_back(acc[`CONV_ACC_WD-1:0]);
            end
            repeat (stim_table[row][2]) drive_idle();
        end
    endtask

    always @(posedge i_clk) begin : cycle_timer
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("timeout after %0d cycles, no result arrived", cycle_count));
        end
    end

    always @(negedge i_clk) begin : output_monitor
        int                             exp_cyc;
        logic signed [`CONV_ACC_WD-1:0] exp_val;
        if (!i_reset) begin
            while (rdy_cyc_q.size() != 0 && rdy_cyc_q[0] <= cycle_count) begin
                void'(rdy_cyc_q.pop_front());
                ready_exp = rdy_val_q.pop_front();
            end
            check_ready(ready_exp, o_weights_ready);
            if (res_cyc_q.size() != 0 && res_cyc_q[0] + 2 < cycle_count) begin
                fail_run("no result arrived two cycles after the ninth pixel");
            end else if (o_result_valid) begin
                if (res_cyc_q.size() == 0) begin
                    fail_run("o_result_valid pulsed with no window pending");
                end else begin
                    exp_cyc = res_cyc_q.pop_front();
                    exp_val = res_val_q.pop_front();
                    if (cycle_count != exp_cyc + 2) begin
                        fail_run($sformatf("result came at cycle %0d instead of cycle %0d",
                                           cycle_count, exp_cyc + 2));
                    end else begin
                        check_result(exp_val, o_result);
                    end
                end
            end
        end
    end

    initial begin : main_sequence
        void'($urandom(32'hfa6a_af86));
        i_reset      = 1'b1;
        i_op         = conv_pkg::OP_NOP;
        i_data_valid = 1'b0;
        i_data       = '0;
        cycle_limit  = reset_cycles + 50;
        for (int r = 0; r < n_rows; r++) begin
            cycle_limit += stim_table[r][1]
                         + (1 + stim_table[r][2]) * `CONV_TAPS * (1 + stim_table[r][0]);
        end
        repeat (reset_cycles) @(posedge i_clk);
        #2;
        i_reset = 1'b0;
        @(negedge i_clk);
        check_ready(1'b0, o_weights_ready);
        if (o_result_valid) begin
            fail_run("o_result_valid is high after reset");
        end
        for (int r = 0; r < n_rows; r++) begin
            for (int n = 0; n < stim_table[r][1]; n++) begin
                drive_strobe(conv_pkg::OP_NOP, fill_word(fill_rand, n));  // must be ignored
            end
            if (stim_table[r][0] != 0) begin
                load_kernel(r);
            end
            run_window(r);
        end
        drive_idle();
        i_op = conv_pkg::OP_NOP;
        while (res_cyc_q.size() != 0) begin
            @(negedge i_clk);
        end
        @(negedge i_clk);  // room for a stray pulse
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
